// File: cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// datapath and register file
`define CPU_XLEN 32
`define CPU_NREGS 32
`define CPU_REG_AW 5

// entries in the wait window
`define CPU_WIN_DEPTH 3

// word addresses
`define CPU_IMEM_AW 12
`define CPU_DMEM_AW 16

`endif

// File: cpu_isa_pkg.sv
`include "cpu_config.svh"

package cpu_isa_pkg;

	typedef enum logic [5:0] {
		op_nop  = 6'h00,
		op_add  = 6'h01,
		op_sub  = 6'h02,
		op_and  = 6'h03,
		op_or   = 6'h04,
		op_xor  = 6'h05,
		op_addi = 6'h08,
		op_lui  = 6'h09,
		op_lw   = 6'h10,
		op_sw   = 6'h11
	} opcode_e;

	typedef enum logic {
		unit_alu,
		unit_lsu
	} unit_e;

	typedef logic [`CPU_REG_AW-1:0] reg_addr_t;

	// rt overlays the top five bits of the 16-bit immediate
	typedef struct packed {
		opcode_e opcode;
		reg_addr_t rd;
		reg_addr_t rs;
		reg_addr_t rt;
		logic [10:0] imm_lo;
	} instr_t;

	typedef struct packed {
		logic valid;
		opcode_e op;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t rd;
		logic [`CPU_XLEN-1:0] imm;
		unit_e unit;
		logic rs_used;
		logic rt_used;
		logic rd_used;
	} decoded_t;

endpackage

// File: cpu_pipe_pkg.sv
`include "cpu_config.svh"

package cpu_pipe_pkg;

	// one issue slot per execution unit
	typedef struct packed {
		logic valid;
		cpu_isa_pkg::opcode_e op;
		cpu_isa_pkg::reg_addr_t rd;
		logic [`CPU_XLEN-1:0] src_a;
		logic [`CPU_XLEN-1:0] src_b;
		logic [`CPU_XLEN-1:0] imm;
	} issue_req_t;

	typedef struct packed {
		logic valid;
		cpu_isa_pkg::reg_addr_t rd;
		logic [`CPU_XLEN-1:0] data;
	} wb_t;

	// wishbone classic master side
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [`CPU_DMEM_AW-1:0] adr;
		logic [`CPU_XLEN-1:0] dat;
	} wbm_req_t;

	typedef struct packed {
		logic ack;
		logic [`CPU_XLEN-1:0] dat;
	} wbm_rsp_t;

endpackage

// File: cpu_fetch_decode.sv
`include "cpu_config.svh"

module cpu_fetch_decode (
	input  logic                    clk,
	input  logic                    rstn,
	output logic [`CPU_IMEM_AW-1:0] o_imem_addr,
	input  logic [`CPU_XLEN-1:0]    i_imem_data,
	input  logic                    i_stall,
	output cpu_isa_pkg::decoded_t   o_instr
);
	import cpu_isa_pkg::*;

	logic [`CPU_IMEM_AW-1:0] pc;
	logic fetch_vld;
	instr_t iw;
	logic [15:0] imm16;
	logic writes;
	decoded_t dec;

	// pc is the address of the word now arriving from the rom
	// on stall the same address goes out again so the word comes back
	assign o_imem_addr = (i_stall || !fetch_vld) ? pc : pc + 1'b1;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			pc <= '0;
			fetch_vld <= 1'b0;
		end else begin
			fetch_vld <= 1'b1;
			if (fetch_vld && !i_stall) begin
				pc <= pc + 1'b1;
			end
		end
	end

	assign iw = instr_t'(i_imem_data);
	assign imm16 = {iw.rt, iw.imm_lo};

	always_comb begin
		dec = '0;
		writes = 1'b0;
		dec.valid = fetch_vld;
		dec.op = iw.opcode;
		dec.unit = unit_alu;
		dec.rs = iw.rs;
		dec.rt = iw.rt;
		dec.imm = {{16{imm16[15]}}, imm16};
		case (iw.opcode)
			op_add, op_sub, op_and, op_or, op_xor: begin
				writes = 1'b1;
				dec.rs_used = 1'b1;
				dec.rt_used = 1'b1;
			end
			op_addi: begin
				writes = 1'b1;
				dec.rs_used = 1'b1;
			end
			op_lui: begin
				writes = 1'b1;
				dec.imm = {imm16, 16'h0000};
			end
			op_lw: begin
				writes = 1'b1;
				dec.rs_used = 1'b1;
				dec.unit = unit_lsu;
			end
			op_sw: begin
				// store data register sits in the rd field
				dec.rs_used = 1'b1;
				dec.rt_used = 1'b1;
				dec.rt = iw.rd;
				dec.unit = unit_lsu;
			end
			default: begin
			end
		endcase
		dec.rd = writes ? iw.rd : '0;
		dec.rd_used = writes && (iw.rd != '0);
	end

	always_ff @(posedge clk) begin
		if (!i_stall) begin
			o_instr <= dec;
		end
		if (!rstn) begin
			o_instr.valid <= 1'b0;
		end
	end

endmodule

// File: cpu_issue_window.sv
`include "cpu_config.svh"

module cpu_issue_window (
	input  logic                          clk,
	input  logic                          rstn,
	input  cpu_isa_pkg::decoded_t         i_instr,
	output logic                          o_full,
	output cpu_isa_pkg::reg_addr_t [3:0]  o_rs_addr,
	input  logic [3:0][`CPU_XLEN-1:0]     i_rs_data,
	input  logic                          i_lsu_busy,
	output cpu_pipe_pkg::issue_req_t      o_alu_req,
	output cpu_pipe_pkg::issue_req_t      o_lsu_req,
	input  cpu_pipe_pkg::wb_t             i_alu_wb,
	input  cpu_pipe_pkg::wb_t             i_lsu_wb
);
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	localparam int DEPTH = `CPU_WIN_DEPTH;
	localparam int CW = $clog2(DEPTH + 1);

	// entry 0 is the oldest
	decoded_t win [DEPTH];
	decoded_t win_nxt [DEPTH];
	logic [`CPU_NREGS-1:0] sb;
	logic [`CPU_NREGS-1:0] sb_nxt;
	logic [DEPTH-1:0] elig;
	logic [DEPTH-1:0] alu_sel;
	logic [DEPTH-1:0] lsu_sel;
	logic [DEPTH-1:0] issued;
	logic [CW-1:0] keep_cnt;
	decoded_t alu_ent;
	decoded_t lsu_ent;

	// younger entry y must wait behind older waiting entry o
	function automatic logic hazard(decoded_t y, decoded_t o);
		logic dst_hit;
		logic src_hit;
		dst_hit = y.rd_used && ((o.rs_used && o.rs == y.rd) ||
			(o.rt_used && o.rt == y.rd) || (o.rd_used && o.rd == y.rd));
		src_hit = o.rd_used && ((y.rs_used && y.rs == o.rd) ||
			(y.rt_used && y.rt == o.rd));
		return o.valid && (dst_hit || src_hit);
	endfunction

	always_comb begin
		for (int i = 0; i < DEPTH; i++) begin
			elig[i] = win[i].valid
				&& !(win[i].rs_used && sb[win[i].rs])
				&& !(win[i].rt_used && sb[win[i].rt])
				&& !(win[i].rd_used && sb[win[i].rd]);
			for (int j = 0; j < i; j++) begin
				if (hazard(win[i], win[j])) begin
					elig[i] = 1'b0;
				end
			end
		end
	end

	// oldest eligible per unit, memory ops strictly in order
	always_comb begin
		logic mem_older;
		alu_sel = '0;
		lsu_sel = '0;
		mem_older = 1'b0;
		for (int i = 0; i < DEPTH; i++) begin
			if (elig[i] && win[i].unit == unit_alu && alu_sel == '0) begin
				alu_sel[i] = 1'b1;
			end
			if (elig[i] && win[i].unit == unit_lsu && !mem_older && !i_lsu_busy) begin
				lsu_sel[i] = 1'b1;
			end
			if (win[i].valid && win[i].unit == unit_lsu) begin
				mem_older = 1'b1;
			end
		end
	end

	assign issued = alu_sel | lsu_sel;

	always_comb begin
		alu_ent = win[0];
		lsu_ent = win[0];
		for (int i = 0; i < DEPTH; i++) begin
			if (alu_sel[i]) begin
				alu_ent = win[i];
			end
			if (lsu_sel[i]) begin
				lsu_ent = win[i];
			end
		end
	end

	// regfile ports 0/1 feed the alu, 2/3 the lsu
	assign o_rs_addr[0] = alu_ent.rs;
	assign o_rs_addr[1] = alu_ent.rt;
	assign o_rs_addr[2] = lsu_ent.rs;
	assign o_rs_addr[3] = lsu_ent.rt;

	assign o_alu_req = '{valid: |alu_sel, op: alu_ent.op, rd: alu_ent.rd,
		src_a: i_rs_data[0], src_b: i_rs_data[1], imm: alu_ent.imm};
	assign o_lsu_req = '{valid: |lsu_sel, op: lsu_ent.op, rd: lsu_ent.rd,
		src_a: i_rs_data[2], src_b: i_rs_data[3], imm: lsu_ent.imm};

	// compact survivors toward entry 0, new instruction goes last
	always_comb begin
		keep_cnt = '0;
		for (int i = 0; i < DEPTH; i++) begin
			win_nxt[i] = win[i];
			win_nxt[i].valid = 1'b0;
		end
		for (int i = 0; i < DEPTH; i++) begin
			if (win[i].valid && !issued[i]) begin
				win_nxt[keep_cnt] = win[i];
				keep_cnt = keep_cnt + 1'b1;
			end
		end
		if (i_instr.valid && keep_cnt < DEPTH) begin
			win_nxt[keep_cnt] = i_instr;
		end
	end

	assign o_full = (keep_cnt == CW'(DEPTH));

	always_ff @(posedge clk) begin
		win <= win_nxt;
		if (!rstn) begin
			for (int i = 0; i < DEPTH; i++) begin
				win[i].valid <= 1'b0;
			end
		end
	end

	always_comb begin
		sb_nxt = sb;
		if (i_alu_wb.valid) begin
			sb_nxt[i_alu_wb.rd] = 1'b0;
		end
		if (i_lsu_wb.valid) begin
			sb_nxt[i_lsu_wb.rd] = 1'b0;
		end
		if (|alu_sel && alu_ent.rd_used) begin
			sb_nxt[alu_ent.rd] = 1'b1;
		end
		if (|lsu_sel && lsu_ent.rd_used) begin
			sb_nxt[lsu_ent.rd] = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			sb <= '0;
		end else begin
			sb <= sb_nxt;
		end
	end

	// a unit only writes back what was issued to it earlier
	a_alu_wb_pending: assert property (@(posedge clk) disable iff (!rstn)
		i_alu_wb.valid && i_alu_wb.rd != '0 |-> sb[i_alu_wb.rd]);
	a_lsu_wb_pending: assert property (@(posedge clk) disable iff (!rstn)
		i_lsu_wb.valid && i_lsu_wb.rd != '0 |-> sb[i_lsu_wb.rd]);
	// memory ops go only to the lsu, everything else only to the alu
	a_issue_disjoint: assert property (@(posedge clk) disable iff (!rstn)
		(o_alu_req.valid |-> !(o_alu_req.op inside {op_lw, op_sw}))
		and (o_lsu_req.valid |-> (o_lsu_req.op inside {op_lw, op_sw})));

endmodule

// File: cpu_regfile.sv
`include "cpu_config.svh"

module cpu_regfile (
	input  logic                         clk,
	input  logic                         rstn,
	input  cpu_isa_pkg::reg_addr_t [3:0] i_rd_addr,
	output logic [3:0][`CPU_XLEN-1:0]    o_rd_data,
	input  cpu_pipe_pkg::wb_t            i_wb_alu,
	input  cpu_pipe_pkg::wb_t            i_wb_lsu
);
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];

	// r0 is never written
	always_ff @(posedge clk) begin
		if (i_wb_alu.valid && i_wb_alu.rd != '0) begin
			regs[i_wb_alu.rd] <= i_wb_alu.data;
		end
		if (i_wb_lsu.valid && i_wb_lsu.rd != '0) begin
			regs[i_wb_lsu.rd] <= i_wb_lsu.data;
		end
	end

	always_comb begin
		for (int p = 0; p < 4; p++) begin
			o_rd_data[p] = (i_rd_addr[p] == '0) ? '0 : regs[i_rd_addr[p]];
		end
	end

	// scoreboard keeps the two units off the same register
	a_wb_no_collide: assert property (@(posedge clk) disable iff (!rstn)
		i_wb_alu.valid && i_wb_lsu.valid && i_wb_alu.rd != '0
		|-> i_wb_alu.rd != i_wb_lsu.rd);

endmodule

// File: cpu_alu.sv
`include "cpu_config.svh"

module cpu_alu (
	input  logic                     clk,
	input  logic                     rstn,
	input  cpu_pipe_pkg::issue_req_t i_req,
	output cpu_pipe_pkg::wb_t        o_wb
);
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	logic [`CPU_XLEN-1:0] res;

	always_comb begin
		case (i_req.op)
			op_add:  res = i_req.src_a + i_req.src_b;
			op_sub:  res = i_req.src_a - i_req.src_b;
			op_and:  res = i_req.src_a & i_req.src_b;
			op_or:   res = i_req.src_a | i_req.src_b;
			op_xor:  res = i_req.src_a ^ i_req.src_b;
			op_addi: res = i_req.src_a + i_req.imm;
			// already shifted by decode
			op_lui:  res = i_req.imm;
			default: res = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		o_wb.rd <= i_req.rd;
		o_wb.data <= res;
		if (!rstn) begin
			o_wb.valid <= 1'b0;
		end else begin
			o_wb.valid <= i_req.valid && i_req.op != op_nop;
		end
	end

endmodule

// File: cpu_lsu.sv
`include "cpu_config.svh"

module cpu_lsu (
	input  logic                     clk,
	input  logic                     rstn,
	input  cpu_pipe_pkg::issue_req_t i_req,
	output logic                     o_busy,
	output cpu_pipe_pkg::wbm_req_t   o_wbm_req,
	input  cpu_pipe_pkg::wbm_rsp_t   i_wbm_rsp,
	output cpu_pipe_pkg::wb_t        o_wb
);
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	typedef enum logic {
		lsu_idle,
		lsu_bus
	} lsu_state_e;

	lsu_state_e state;
	logic [`CPU_XLEN-1:0] ea;
	logic [`CPU_DMEM_AW-1:0] adr_q;
	logic [`CPU_XLEN-1:0] dat_q;
	logic we_q;
	reg_addr_t rd_q;
	logic done;

	// word address
	assign ea = i_req.src_a + i_req.imm;
	assign done = (state == lsu_bus) && i_wbm_rsp.ack;
	assign o_busy = (state == lsu_bus);
	assign o_wbm_req = '{cyc: o_busy, stb: o_busy, we: we_q, adr: adr_q, dat: dat_q};

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= lsu_idle;
		end else begin
			case (state)
				lsu_idle: begin
					if (i_req.valid) begin
						state <= lsu_bus;
					end
				end
				lsu_bus: begin
					if (i_wbm_rsp.ack) begin
						state <= lsu_idle;
					end
				end
				default: state <= lsu_idle;
			endcase
		end
	end

	// request held steady for the whole bus cycle
	always_ff @(posedge clk) begin
		if (state == lsu_idle && i_req.valid) begin
			adr_q <= ea[`CPU_DMEM_AW-1:0];
			dat_q <= i_req.src_b;
			we_q <= (i_req.op == op_sw);
			rd_q <= i_req.rd;
		end
	end

	// load data written back the cycle after ack
	always_ff @(posedge clk) begin
		if (done) begin
			o_wb.rd <= rd_q;
			o_wb.data <= i_wbm_rsp.dat;
		end
		if (!rstn) begin
			o_wb.valid <= 1'b0;
		end else begin
			o_wb.valid <= done && !we_q;
		end
	end

	a_req_stable: assert property (@(posedge clk) disable iff (!rstn)
		o_wbm_req.stb && !i_wbm_rsp.ack |=> o_wbm_req.stb
		&& $stable(o_wbm_req.adr) && $stable(o_wbm_req.dat) && $stable(o_wbm_req.we));

endmodule

// File: cpu_core.sv
`include "cpu_config.svh"

module cpu_core (
	input  logic                    clk,
	input  logic                    rstn,
	output logic [`CPU_IMEM_AW-1:0] o_imem_addr,
	input  logic [`CPU_XLEN-1:0]    i_imem_data,
	output cpu_pipe_pkg::wbm_req_t  o_dmem_req,
	input  cpu_pipe_pkg::wbm_rsp_t  i_dmem_rsp
);
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	decoded_t dec_instr;
	logic win_full;
	reg_addr_t [3:0] rf_addr;
	logic [3:0][`CPU_XLEN-1:0] rf_data;
	logic lsu_busy;
	issue_req_t alu_req;
	issue_req_t lsu_req;
	wb_t alu_wb;
	wb_t lsu_wb;

	cpu_fetch_decode u_fetch (
		.clk         (clk),
		.rstn        (rstn),
		.o_imem_addr (o_imem_addr),
		.i_imem_data (i_imem_data),
		.i_stall     (win_full),
		.o_instr     (dec_instr)
	);

	cpu_issue_window u_win (
		.clk        (clk),
		.rstn       (rstn),
		.i_instr    (dec_instr),
		.o_full     (win_full),
		.o_rs_addr  (rf_addr),
		.i_rs_data  (rf_data),
		.i_lsu_busy (lsu_busy),
		.o_alu_req  (alu_req),
		.o_lsu_req  (lsu_req),
		.i_alu_wb   (alu_wb),
		.i_lsu_wb   (lsu_wb)
	);

	cpu_regfile u_rf (
		.clk       (clk),
		.rstn      (rstn),
		.i_rd_addr (rf_addr),
		.o_rd_data (rf_data),
		.i_wb_alu  (alu_wb),
		.i_wb_lsu  (lsu_wb)
	);

	cpu_alu u_alu (
		.clk   (clk),
		.rstn  (rstn),
		.i_req (alu_req),
		.o_wb  (alu_wb)
	);

	cpu_lsu u_lsu (
		.clk       (clk),
		.rstn      (rstn),
		.i_req     (lsu_req),
		.o_busy    (lsu_busy),
		.o_wbm_req (o_dmem_req),
		.i_wbm_rsp (i_dmem_rsp),
		.o_wb      (lsu_wb)
	);

endmodule

// File: tb_mem_model.sv
`include "cpu_config.svh"

module tb_mem_model (
	input  logic                    clk,
	input  logic                    rstn,
	input  logic [`CPU_IMEM_AW-1:0] i_imem_addr,
	output logic [`CPU_XLEN-1:0]    o_imem_data,
	input  cpu_pipe_pkg::wbm_req_t  i_dmem_req,
	output cpu_pipe_pkg::wbm_rsp_t  o_dmem_rsp
);
	timeunit 1ns;
	timeprecision 100ps;
	import cpu_pipe_pkg::*;

	logic [`CPU_XLEN-1:0] rom [2**`CPU_IMEM_AW];
	logic [`CPU_XLEN-1:0] ram [2**`CPU_DMEM_AW];
	integer seed = 32'h32a2_08b1;
	logic in_cyc;
	int wait_left;
	int delay;

	initial begin
		o_imem_data = '0;
		o_dmem_rsp = '0;
	end

	// words past the program execute as nop
	task automatic fill();
		for (int a = 0; a < 2**`CPU_IMEM_AW; a++) begin
			rom[a] = '0;
		end
		for (int a = 0; a < 2**`CPU_DMEM_AW; a++) begin
			ram[a] = {~16'(a), 16'(a)};
		end
	endtask

	task automatic set_rom(input int adr, input logic [`CPU_XLEN-1:0] val);
		rom[adr] = val;
	endtask

	task automatic set_ram(input logic [`CPU_DMEM_AW-1:0] adr, input logic [`CPU_XLEN-1:0] val);
		ram[adr] = val;
	endtask

	// one cycle read latency
	always @(posedge clk) begin
		o_imem_data <= rom[i_imem_addr];
	end

	// registered ack after 0 to 3 wait cycles
	always @(posedge clk) begin
		if (!rstn) begin
			o_dmem_rsp.ack <= 1'b0;
			in_cyc <= 1'b0;
		end else if (o_dmem_rsp.ack) begin
			o_dmem_rsp.ack <= 1'b0;
			in_cyc <= 1'b0;
		end else if (i_dmem_req.cyc && i_dmem_req.stb) begin
			if (!in_cyc) begin
				delay = $random(seed) & 3;
			end else begin
				delay = wait_left;
			end
			in_cyc <= 1'b1;
			if (delay == 0) begin
				o_dmem_rsp.ack <= 1'b1;
				o_dmem_rsp.dat <= ram[i_dmem_req.adr];
				if (i_dmem_req.we) begin
					ram[i_dmem_req.adr] <= i_dmem_req.dat;
				end
			end else begin
				wait_left <= delay - 1;
			end
		end
	end

endmodule

// File: tb_cpu_core.sv
`include "cpu_config.svh"

module tb_cpu_core;
	timeunit 1ns;
	timeprecision 100ps;
	import cpu_pipe_pkg::*;

	logic clk = 1'b0;
	logic rstn;
	logic [`CPU_IMEM_AW-1:0] imem_addr;
	logic [`CPU_XLEN-1:0] imem_data;
	wbm_req_t dmem_req;
	wbm_rsp_t dmem_rsp;

	string exp_name [$];
	logic [`CPU_DMEM_AW-1:0] exp_adr [$];
	logic [`CPU_XLEN-1:0] exp_dat [$];
	int n_prog = 0;
	int n_checked = 0;
	int errors = 0;
	int test_errors = 0;
	int n_pass = 0;
	int n_fail = 0;
	string cur_test = "";
	bit running = 1'b0;

	always #4 clk = ~clk;

	cpu_core uut (
		.clk         (clk),
		.rstn        (rstn),
		.o_imem_addr (imem_addr),
		.i_imem_data (imem_data),
		.o_dmem_req  (dmem_req),
		.i_dmem_rsp  (dmem_rsp)
	);

	tb_mem_model u_mem (
		.clk         (clk),
		.rstn        (rstn),
		.i_imem_addr (imem_addr),
		.o_imem_data (imem_data),
		.i_dmem_req  (dmem_req),
		.o_dmem_rsp  (dmem_rsp)
	);

	task automatic check_value(input string test, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		if (actual !== expected) begin
			$display("[FAIL] %s %s expected %h actual %h", test, what, expected, actual);
			errors++;
			test_errors++;
		end
	endtask

	task automatic close_test();
		if (test_errors == 0) begin
			$display("test %-12s ok", cur_test);
			n_pass++;
		end else begin
			$display("test %-12s failed with %0d mismatches", cur_test, test_errors);
			n_fail++;
		end
	endtask

	// stores are compared in program order against the trace
	task automatic check_store(input logic [`CPU_DMEM_AW-1:0] adr, input logic [`CPU_XLEN-1:0] dat);
		if (n_checked >= exp_adr.size()) begin
			$display("unexpected store of %h to address %h after the last expected one", dat, adr);
			errors++;
		end else begin
			if (n_checked == 0 || exp_name[n_checked] != exp_name[n_checked - 1]) begin
				cur_test = exp_name[n_checked];
				test_errors = 0;
			end
			check_value(cur_test, "address", exp_adr[n_checked], adr);
			check_value(cur_test, "data", exp_dat[n_checked], dat);
			n_checked++;
			if (n_checked == exp_adr.size() || exp_name[n_checked] != cur_test) begin
				close_test();
			end
		end
	endtask

	task automatic load_trace();
		int fd;
		int n;
		string line;
		string kind;
		string name;
		logic [31:0] a;
		logic [31:0] d;
		fd = $fopen("cpu_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open cpu_trace.txt");
			errors++;
			return;
		end
		u_mem.fill();
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 0 && line.len() > 1 && line.substr(0, 0) != "#") begin
				n = $sscanf(line, "%s", kind);
				if (kind == "p") begin
					n = $sscanf(line, "%s %h", kind, d);
					u_mem.set_rom(n_prog, d);
					n_prog++;
				end else if (kind == "m") begin
					n = $sscanf(line, "%s %h %h", kind, a, d);
					u_mem.set_ram(a[`CPU_DMEM_AW-1:0], d);
				end else if (kind == "s") begin
					n = $sscanf(line, "%s %s %h %h", kind, name, a, d);
					exp_name.push_back(name);
					exp_adr.push_back(a[`CPU_DMEM_AW-1:0]);
					exp_dat.push_back(d);
				end else begin
					$display("trace line not understood: %s", line);
					errors++;
				end
			end
		end
		$fclose(fd);
	endtask

	always @(posedge clk) begin
		if (rstn && dmem_req.cyc && dmem_req.stb && dmem_req.we && dmem_rsp.ack) begin
			check_store(dmem_req.adr, dmem_req.dat);
		end
	end

	initial begin
		wait (running);
		repeat (50 * n_prog) @(posedge clk);
		$display("timeout after %0d cycles with %0d of %0d stores seen",
			50 * n_prog, n_checked, exp_adr.size());
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		rstn = 1'b0;
		load_trace();
		if (n_prog == 0 || exp_adr.size() == 0) begin
			$display("trace gave no program words or no expected stores");
			errors++;
		end else begin
			running = 1'b1;
			repeat (2) @(posedge clk);
			rstn <= 1'b1;
			wait (n_checked == exp_adr.size());
			// room for a stray extra store to show up
			repeat (20) @(posedge clk);
		end
		$display("tests passed %0d failed %0d, stores checked %0d of %0d, errors %0d",
			n_pass, n_fail, n_checked, exp_adr.size(), errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// File: cpu_core.f
+incdir+.
cpu_isa_pkg.sv
cpu_pipe_pkg.sv
cpu_fetch_decode.sv
cpu_issue_window.sv
cpu_regfile.sv
cpu_alu.sv
cpu_lsu.sv
cpu_core.sv
tb_mem_model.sv
tb_cpu_core.sv

// File: Bender.yml
package:
  name: cpu_core

sources:
  - include_dirs:
      - .
    files:
      - cpu_isa_pkg.sv
      - cpu_pipe_pkg.sv
      - cpu_fetch_decode.sv
      - cpu_issue_window.sv
      - cpu_regfile.sv
      - cpu_alu.sv
      - cpu_lsu.sv
      - cpu_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_mem_model.sv
      - tb_cpu_core.sv

// File: cpu_trace.txt
# p <instr word> | m <data word addr> <value> | s <test> <store addr> <store data>
# store records are listed in program order
p 24201234 # lui  r1, 0x1234
p 20215678 # addi r1, r1, 0x5678
p 2040fffd # addi r2, r0, -3
p 20600f0f # addi r3, r0, 0x0f0f
p 04811000 # add  r4, r1, r2
p 08a11800 # sub  r5, r1, r3
p 0cc11800 # and  r6, r1, r3
p 10e11800 # or   r7, r1, r3
p 15011000 # xor  r8, r1, r2
p 44800100 # sw   r4, 0x100(r0)
p 44a00101 # sw   r5, 0x101(r0)
p 44c00102 # sw   r6, 0x102(r0)
p 44e00103 # sw   r7, 0x103(r0)
p 45000104 # sw   r8, 0x104(r0)
p 44200110 # sw   r1, 0x110(r0)
p 44400111 # sw   r2, 0x111(r0)
p 41400200 # lw   r10, 0x200(r0)
p 056a1800 # add  r11, r10, r3
p 45600120 # sw   r11, 0x120(r0)
p 22200300 # addi r17, r0, 0x300
p 4431ffff # sw   r1, -1(r17)
p 45710001 # sw   r11, 1(r17)
p 20000055 # addi r0, r0, 0x55
p 44000130 # sw   r0, 0x130(r0)
p 21800007 # addi r12, r0, 7
p 45800131 # sw   r12, 0x131(r0)
p 41a00201 # lw   r13, 0x201(r0)
p 21ec0010 # addi r15, r12, 0x10
p 44600141 # sw   r3, 0x141(r0)
p 20600022 # addi r3, r0, 0x22
p 160f6000 # xor  r16, r15, r12
p 05cd8000 # add  r14, r13, r16
p 45c00140 # sw   r14, 0x140(r0)
p 44600142 # sw   r3, 0x142(r0)
p 46000143 # sw   r16, 0x143(r0)
m 0200 00c0ffee
m 0201 a5a50001
s alu_rr 0100 12345675
s alu_rr 0101 12344769
s alu_rr 0102 00000608
s alu_rr 0103 12345f7f
s alu_rr 0104 edcba985
s imm_forms 0110 12345678
s imm_forms 0111 fffffffd
s load_use 0120 00c10efd
s store_order 02ff 12345678
s store_order 0301 00c10efd
s r0_zero 0130 00000000
s r0_zero 0131 00000007
s window 0141 00000f0f
s window 0140 a5a50011
s window 0142 00000022
s window 0143 00000010
